//--- include/udp_mailbox_settings.svh
`ifndef UDP_MAILBOX_SETTINGS_SVH
`define UDP_MAILBOX_SETTINGS_SVH

// destination port the mailbox answers on
`define UDP_MAILBOX_LISTEN_PORT 16'd2390

// receive and transmit word width
`define UDP_MAILBOX_BUFFER_BITS 80

// bytes per reply to match the width above
`define UDP_MAILBOX_BUFFER_BYTES 10

`endif

//--- verilog/udp_mailbox_pkg.sv
`include "udp_mailbox_settings.svh"

package udp_mailbox_pkg;

    // ipv4 address as delivered by the core
    typedef logic [31:0] ip_addr_t;

    typedef logic [15:0] udp_port_t;

    // third header word with the source port on top
    typedef struct packed {
        udp_port_t src;
        udp_port_t dst;
    } port_pair_t;

    // one head word read either as address or as ports
    // depending on which word cycle it arrives in
    typedef union packed {
        ip_addr_t   ip;
        port_pair_t ports;
    } head_word_u;

    // rx and tx payload word
    typedef logic [`UDP_MAILBOX_BUFFER_BITS-1:0] mailbox_word_t;

endpackage

//--- verilog/rx_frame_if.sv
`timescale 1ns/1ns

interface rx_frame_if;

    import udp_mailbox_pkg::*;

    ip_addr_t  peer_ip;
    udp_port_t peer_port;
    logic      accept;
    logic      done;

    modport parser (
        output peer_ip,
        output peer_port,
        output accept,
        input  done
    );

    modport collector (
        input  accept,
        output done
    );

    modport sender (
        input  peer_ip,
        input  peer_port,
        input  done
    );

endinterface

//--- verilog/rx_header_parser.sv
`timescale 1ns/1ns
`include "udp_mailbox_settings.svh"

module rx_header_parser (
    input  logic                        clk50m,
    input  logic                        ready,
    input  logic                        head_av_i,
    input  udp_mailbox_pkg::head_word_u head_i,
    output logic                        head_rdy_o,
    rx_frame_if.parser                  frame
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_HEAD,
        ST_WAIT
    } state_t;

    state_t     state;
    logic [1:0] word_cnt;

    always_ff @(posedge clk50m or negedge ready) begin
        if (!ready) begin
            state        <= ST_IDLE;
            word_cnt     <= 2'd0;
            head_rdy_o   <= 1'b0;
            frame.accept <= 1'b0;
        end else begin
            head_rdy_o   <= 1'b0;
            frame.accept <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (head_av_i) begin
                        head_rdy_o <= 1'b1;
                        state      <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    // core puts word 0 out next cycle
                    word_cnt <= 2'd0;
                    state    <= ST_HEAD;
                end
                ST_HEAD: begin
                    word_cnt <= word_cnt + 2'd1;
                    if (word_cnt == 2'd2) begin
                        if (head_i.ports.dst == `UDP_MAILBOX_LISTEN_PORT) begin
                            frame.accept <= 1'b1;
                            state        <= ST_WAIT;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_WAIT: begin
                    // hold off the next header until the payload is in
                    if (frame.done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // peer address from word 0 and the source half of a matching word 2
    always_ff @(posedge clk50m) begin
        if (state == ST_HEAD && word_cnt == 2'd0) begin
            frame.peer_ip <= head_i.ip;
        end
        if (state == ST_HEAD && word_cnt == 2'd2
                && head_i.ports.dst == `UDP_MAILBOX_LISTEN_PORT) begin
            frame.peer_port <= head_i.ports.src;
        end
    end

    a_head_rdy_pulse: assert property (
        @(posedge clk50m) disable iff (!ready)
        head_rdy_o |=> !head_rdy_o
    );

endmodule

//--- verilog/rx_payload_collector.sv
`timescale 1ns/1ns
`include "udp_mailbox_settings.svh"

module rx_payload_collector (
    input  logic                           clk50m,
    input  logic                           ready,
    input  logic                           data_av_i,
    input  logic [7:0]                     data_i,
    output udp_mailbox_pkg::mailbox_word_t rx_data_o,
    rx_frame_if.collector                  frame
);

    import udp_mailbox_pkg::*;

    mailbox_word_t shift_q;
    logic          busy;
    logic          take_byte;

    // first byte comes in the same cycle as accept
    assign take_byte = (busy || frame.accept) && data_av_i;

    always_ff @(posedge clk50m or negedge ready) begin
        if (!ready) begin
            busy       <= 1'b0;
            frame.done <= 1'b0;
        end else begin
            frame.done <= 1'b0;
            if (frame.accept) begin
                busy <= 1'b1;
            end else if (busy && !data_av_i) begin
                busy       <= 1'b0;
                frame.done <= 1'b1;
            end
        end
    end

    // shift register persists across frames
    // short payloads leave older bytes above the new ones
    always_ff @(posedge clk50m or negedge ready) begin
        if (!ready) begin
            shift_q   <= '0;
            rx_data_o <= '0;
        end else begin
            if (take_byte) begin
                shift_q <= {shift_q[`UDP_MAILBOX_BUFFER_BITS-9:0], data_i};
            end
            if (busy && !data_av_i) begin
                rx_data_o <= shift_q;
            end
        end
    end

    // parser must be parked while the payload completes
    a_done_not_accept: assert property (
        @(posedge clk50m) disable iff (!ready)
        !(frame.done && frame.accept)
    );

endmodule

//--- verilog/reply_sender.sv
`timescale 1ns/1ns
`include "udp_mailbox_settings.svh"

module reply_sender (
    input  logic                           clk50m,
    input  logic                           ready,
    input  udp_mailbox_pkg::mailbox_word_t tx_data_i,
    input  logic                           tx_req_rdy_i,
    output logic [7:0]                     tx_data_o,
    output logic                           tx_data_av_o,
    output logic                           tx_req_o,
    output udp_mailbox_pkg::ip_addr_t      tx_ip_o,
    output udp_mailbox_pkg::udp_port_t     tx_dst_port_o,
    rx_frame_if.sender                     frame
);

    import udp_mailbox_pkg::*;

    localparam int CNT_W = $clog2(`UDP_MAILBOX_BUFFER_BYTES + 1);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(`UDP_MAILBOX_BUFFER_BYTES);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_REQ
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] byte_cnt;
    mailbox_word_t    tx_shift;
    logic             capture;
    logic             send_next;

    // a reply arriving while busy or with the core not ready is lost
    assign capture   = (state == ST_IDLE) && frame.done && tx_req_rdy_i;
    assign send_next = (state == ST_SEND) && (byte_cnt != LAST_BYTE);

    // request goes out in the first ready cycle
    assign tx_req_o = (state == ST_REQ) && tx_req_rdy_i;

    always_ff @(posedge clk50m or negedge ready) begin
        if (!ready) begin
            state        <= ST_IDLE;
            byte_cnt     <= '0;
            tx_data_av_o <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (capture) begin
                        tx_data_av_o <= 1'b1;
                        byte_cnt     <= CNT_W'(1);
                        state        <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (send_next) begin
                        byte_cnt <= byte_cnt + 1'b1;
                    end else begin
                        tx_data_av_o <= 1'b0;
                        state        <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (tx_req_o) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // msb first out of the captured word
    always_ff @(posedge clk50m) begin
        if (capture) begin
            tx_data_o     <= tx_data_i[`UDP_MAILBOX_BUFFER_BITS-1 -: 8];
            tx_shift      <= {tx_data_i[`UDP_MAILBOX_BUFFER_BITS-9:0], 8'h00};
            tx_ip_o       <= frame.peer_ip;
            tx_dst_port_o <= frame.peer_port;
        end else if (send_next) begin
            tx_data_o <= tx_shift[`UDP_MAILBOX_BUFFER_BITS-1 -: 8];
            tx_shift  <= {tx_shift[`UDP_MAILBOX_BUFFER_BITS-9:0], 8'h00};
        end
    end

    a_req_when_ready: assert property (
        @(posedge clk50m) disable iff (!ready)
        tx_req_o |-> tx_req_rdy_i ##1 !tx_req_o
    );

endmodule

//--- verilog/udp_mailbox.sv
`timescale 1ns/1ns

module udp_mailbox (
    input  logic                           clk50m,
    input  logic                           ready,
    input  logic                           head_av_i,
    input  logic [31:0]                    head_i,
    output logic                           head_rdy_o,
    input  logic                           data_av_i,
    input  logic [7:0]                     data_i,
    output udp_mailbox_pkg::mailbox_word_t rx_data_o,
    input  udp_mailbox_pkg::mailbox_word_t tx_data_i,
    input  logic                           tx_req_rdy_i,
    output logic [7:0]                     tx_data_o,
    output logic                           tx_data_av_o,
    output logic                           tx_req_o,
    output udp_mailbox_pkg::ip_addr_t      tx_ip_o,
    output udp_mailbox_pkg::udp_port_t     tx_dst_port_o
);

    rx_frame_if frame_if ();

    // header words and port filter
    rx_header_parser i_rx_header_parser (
        .clk50m     (clk50m),
        .ready      (ready),
        .head_av_i  (head_av_i),
        .head_i     (head_i),
        .head_rdy_o (head_rdy_o),
        .frame      (frame_if.parser)
    );

    rx_payload_collector i_rx_payload_collector (
        .clk50m    (clk50m),
        .ready     (ready),
        .data_av_i (data_av_i),
        .data_i    (data_i),
        .rx_data_o (rx_data_o),
        .frame     (frame_if.collector)
    );

    // reply back to the peer of the last accepted frame
    reply_sender i_reply_sender (
        .clk50m        (clk50m),
        .ready         (ready),
        .tx_data_i     (tx_data_i),
        .tx_req_rdy_i  (tx_req_rdy_i),
        .tx_data_o     (tx_data_o),
        .tx_data_av_o  (tx_data_av_o),
        .tx_req_o      (tx_req_o),
        .tx_ip_o       (tx_ip_o),
        .tx_dst_port_o (tx_dst_port_o),
        .frame         (frame_if.sender)
    );

endmodule

//--- tb/tb_udp_mailbox.sv
`timescale 1ns/1ns
`include "udp_mailbox_settings.svh"

module tb_udp_mailbox;

    import udp_mailbox_pkg::*;

    localparam int FRAMES = 40;
    localparam int LIMIT  = 50;
    localparam int NBITS  = `UDP_MAILBOX_BUFFER_BITS;

    typedef struct packed {
        ip_addr_t      ip;
        udp_port_t     port;
        mailbox_word_t word;
    } reply_t;

    logic          clk50m;
    logic          ready;
    logic          head_av_i;
    logic [31:0]   head_i;
    logic          head_rdy_o;
    logic          data_av_i;
    logic [7:0]    data_i;
    mailbox_word_t rx_data_o;
    mailbox_word_t tx_data_i;
    logic          tx_req_rdy_i;
    logic [7:0]    tx_data_o;
    logic          tx_data_av_o;
    logic          tx_req_o;
    ip_addr_t      tx_ip_o;
    udp_port_t     tx_dst_port_o;

    // reference model state
    mailbox_word_t model_shift;
    reply_t        exp_q[$];
    reply_t        exp_reply;
    ip_addr_t      ip;
    port_pair_t    ports;
    logic          accepted;
    logic          reply_open;
    int            errors;
    int            timeouts;
    int            low_run;
    int            wait_cnt;
    int            len;

    udp_mailbox i_udp_mailbox (.*);

    always #10 clk50m = ~clk50m;

    task automatic next_cycle();
        @(posedge clk50m);
        #2;
    endtask

    // core tx ready with low runs of at most four cycles
    task automatic drive_req_rdy();
        tx_req_rdy_i = (low_run >= 4) || ($urandom % 2 == 1);
        low_run      = tx_req_rdy_i ? 0 : low_run + 1;
    endtask

    task automatic reply_cycle();
        next_cycle();
        drive_req_rdy();
        @(negedge clk50m);
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, want);
        end
    endtask

    task automatic check_rx_data(input mailbox_word_t got, input mailbox_word_t want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] rx_data_o: got 0x%h expected 0x%h", got, want);
        end
    endtask

    task automatic check_reply_byte(input logic [7:0] got, input logic [7:0] want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] tx_data_o: got 0x%h expected 0x%h", got, want);
        end
    endtask

    task automatic check_reply_addr(input ip_addr_t got_ip, input ip_addr_t want_ip,
                                    input udp_port_t got_port, input udp_port_t want_port);
        if (got_ip !== want_ip) begin
            errors++;
            $display("[FAIL] tx_ip_o: got 0x%h expected 0x%h", got_ip, want_ip);
        end
        if (got_port !== want_port) begin
            errors++;
            $display("[FAIL] tx_dst_port_o: got 0x%h expected 0x%h", got_port, want_port);
        end
    endtask

    task automatic end_run();
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic note_timeout(input string why);
        timeouts++;
        $display("timeout: %s", why);
    endtask

    // ten bytes msb first and one request to the peer
    task automatic check_reply();
        exp_reply = exp_q.pop_front();
        wait_cnt  = 0;
        do begin
            reply_cycle();
            wait_cnt++;
        end while (!tx_data_av_o && wait_cnt < LIMIT);
        if (!tx_data_av_o) begin
            note_timeout("tx_data_av_o never rose for an accepted datagram");
        end else begin
            if (wait_cnt != 1) begin
                errors++;
                $display("reply bytes started %0d cycles after done, not 1", wait_cnt);
            end
            for (int k = 0; k < `UDP_MAILBOX_BUFFER_BYTES; k++) begin
                if (k > 0) begin
                    reply_cycle();
                end
                check_flag("tx_data_av_o", tx_data_av_o, 1'b1);
                check_reply_byte(tx_data_o, exp_reply.word[NBITS-1-8*k -: 8]);
            end
            wait_cnt = 0;
            do begin
                reply_cycle();
                wait_cnt++;
                check_flag("tx_data_av_o", tx_data_av_o, 1'b0);
            end while (!tx_req_o && wait_cnt < LIMIT);
            if (!tx_req_o) begin
                note_timeout("tx_req_o never pulsed for a pending reply");
            end else begin
                check_reply_addr(tx_ip_o, exp_reply.ip, tx_dst_port_o, exp_reply.port);
            end
        end
    endtask

    // one datagram from the core model
    task automatic run_frame();
        ip        = $urandom();
        ports.src = 16'($urandom());
        ports.dst = `UDP_MAILBOX_LISTEN_PORT;
        if ($urandom % 4 == 0) begin
            ports.dst = 16'($urandom());
            while (ports.dst == `UDP_MAILBOX_LISTEN_PORT) begin
                ports.dst = 16'($urandom());
            end
        end
        accepted = (ports.dst == `UDP_MAILBOX_LISTEN_PORT);
        len      = 1 + $urandom % 14;

        next_cycle();
        head_av_i = 1'b1;
        @(negedge clk50m);
        check_flag("head_rdy_o", head_rdy_o, 1'b0);
        wait_cnt = 0;
        do begin
            next_cycle();
            @(negedge clk50m);
            wait_cnt++;
        end while (!head_rdy_o && wait_cnt < LIMIT);
        if (!head_rdy_o) begin
            note_timeout("head_rdy_o never answered head_av_i");
        end else begin
            if (wait_cnt != 1) begin
                errors++;
                $display("head_rdy_o came %0d cycles after head_av_i rose, not 1", wait_cnt);
            end

            // header words and the payload
            next_cycle();
            head_av_i = 1'b0;
            head_i    = ip;
            @(negedge clk50m);
            check_flag("head_rdy_o", head_rdy_o, 1'b0);
            next_cycle();
            head_i = {16'(8 + len), 16'h0000};
            next_cycle();
            head_i       = ports;
            tx_req_rdy_i = 1'b1;
            for (int k = 0; k < len; k++) begin
                next_cycle();
                head_i    = $urandom();
                data_av_i = 1'b1;
                data_i    = 8'($urandom());
                if (accepted) begin
                    model_shift = {model_shift[NBITS-9:0], data_i};
                end
            end
            next_cycle();
            data_av_i = 1'b0;
            next_cycle();
            reply_open = accepted;
            @(negedge clk50m);
            check_rx_data(rx_data_o, model_shift);
            if (accepted) begin
                exp_q.push_back(reply_t'({ip, ports.src, tx_data_i}));
                check_reply();
            end
        end
    endtask

    // reply traffic only while a reply is pending
    always @(negedge clk50m) begin
        if (ready && !reply_open && (tx_data_av_o || tx_req_o)) begin
            errors++;
            $display("reply traffic at %0t with no accepted datagram pending", $time);
        end
        if (ready && tx_req_o && !tx_req_rdy_i) begin
            errors++;
            $display("tx_req_o high at %0t while tx_req_rdy_i was low", $time);
        end
    end

    initial begin
        void'($urandom(32'hcffa885a));
        clk50m       = 1'b0;
        ready        = 1'b0;
        head_av_i    = 1'b0;
        head_i       = '0;
        data_av_i    = 1'b0;
        data_i       = '0;
        tx_data_i    = '0;
        tx_req_rdy_i = 1'b0;
        model_shift  = '0;
        reply_open   = 1'b0;
        errors       = 0;
        timeouts     = 0;
        low_run      = 0;

        // three reset cycles and the first one after release
        for (int i = 0; i < 4; i++) begin
            next_cycle();
            ready = (i >= 2);
            @(negedge clk50m);
            check_flag("head_rdy_o", head_rdy_o, 1'b0);
            check_flag("tx_data_av_o", tx_data_av_o, 1'b0);
            check_flag("tx_req_o", tx_req_o, 1'b0);
            check_rx_data(rx_data_o, '0);
        end

        for (int f = 0; f < FRAMES && timeouts == 0; f++) begin
            repeat (1 + $urandom % 6) begin
                next_cycle();
                reply_open = 1'b0;
                drive_req_rdy();
            end
            tx_data_i = {16'($urandom()), $urandom(), $urandom()};
            run_frame();
        end
        repeat (8) begin
            next_cycle();
            reply_open = 1'b0;
        end
        end_run();
    end

endmodule

//--- udp_mailbox.f
+incdir+include
verilog/udp_mailbox_pkg.sv
verilog/rx_frame_if.sv
verilog/rx_header_parser.sv
verilog/rx_payload_collector.sv
verilog/reply_sender.sv
verilog/udp_mailbox.sv
tb/tb_udp_mailbox.sv

//--- Bender.yml
package:
  name: udp_mailbox

sources:
  - include_dirs:
      - include
    files:
      - verilog/udp_mailbox_pkg.sv
      - verilog/rx_frame_if.sv
      - verilog/rx_header_parser.sv
      - verilog/rx_payload_collector.sv
      - verilog/reply_sender.sv
      - verilog/udp_mailbox.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_udp_mailbox.sv
